// File: common/DrainBufferPkg.sv
//----------------------------------------------------------
// shared types of the burst-drain buffer
// data word, fill level, sequencer state, burst count
//----------------------------------------------------------
`include "drainBuffer_consts.svh"

package DrainBufferPkg;

	// one fifo data word
	typedef logic [`DATA_WIDTH-1:0] tWord;

	// fill level, 0..15 for depth 16
	typedef logic [4:0] tLevel;

	// drain sequencer states
	typedef enum logic [1:0]
	{
		Idle,
		Drain,
		Hold
	} tDrainState;

	// words read so far in the current burst
	typedef logic [2:0] tBurstCnt;

endpackage

// File: common/drainBuffer_consts.svh
//----------------------------------------------------------
// burst-drain buffer constants
// fifo depth, word width, alert border, burst and idle time
//----------------------------------------------------------
`ifndef DRAINBUFFER_CONSTS_SVH
`define DRAINBUFFER_CONSTS_SVH

// ram words, one slot stays free so 15 words usable
`define FIFO_DEPTH		16

// byte words
`define DATA_WIDTH		8

// fill level that raises the alert
`define ALERT_BORDER	8

// max words per drain burst
`define BURST_LEN		4

// write-free cycles before a non-empty fifo is flushed
`define IDLE_CYCLES		20

`endif

// File: fifo/SyncFifoController.sv
//----------------------------------------------------------
// single-clock fifo controller
// pointers, full/empty flags, level, registered alert
// read-valid and last flag output stage, ram slice array
//----------------------------------------------------------
`timescale 1ns/1ns

module SyncFifoController #(
	parameter int pFifoDepth	= 16,
	parameter int pFifoBitWidth	= 8,
	parameter int pAlertBorder	= pFifoDepth / 2
)(
	input	logic					iCLK,
	input	logic					inARST,
	// write side
	input	DrainBufferPkg::tWord	iWd,
	input	logic					iWe,
	output	logic					oFull,
	output	logic					oWrote,
	// read side
	input	logic					iRe,
	input	logic					iLastRead,
	output	DrainBufferPkg::tWord	oRd,
	output	logic					oRvd,
	output	logic					oLast,
	output	logic					oEmp,
	// fill state
	output	logic					oAlert,
	output	DrainBufferPkg::tLevel	oLevel
);

	import DrainBufferPkg::*;

	//----------------------------------------------------------
	// slice geometry
	//----------------------------------------------------------
	// slice width from the block ram depth table
	function automatic int fSliceWidth(input int depth);
		case (depth)
			256:		return 16;
			512:		return 8;
			1024:		return 4;
			2048:		return 2;
			4096:		return 1;
			default:	return 1;
		endcase
	endfunction

	localparam int lpAddrWidth	= $clog2(pFifoDepth);
	localparam int lpSliceWidth	= fSliceWidth(pFifoDepth);
	// round up so every data bit lands in a slice
	localparam int lpSliceNum	= (pFifoBitWidth + lpSliceWidth - 1) / lpSliceWidth;
	localparam int lpPadWidth	= lpSliceNum * lpSliceWidth;
	localparam tLevel lpBorder	= tLevel'(pAlertBorder);

	//----------------------------------------------------------
	// pointers and flags
	//----------------------------------------------------------
	logic [lpAddrWidth-1:0] rWa;
	logic [lpAddrWidth-1:0] rRa;
	logic [lpAddrWidth-1:0] wWaNext;
	logic [lpAddrWidth-1:0] wCount;
	logic qWe;
	logic qRe;
	logic rRvd;
	logic rLast;
	logic rAlert;

	assign wWaNext	= rWa + 1'b1;
	// full one slot early so full and empty stay apart
	assign oFull	= (wWaNext == rRa);
	assign oEmp		= (rWa == rRa);
	// mask strobes with the flags
	assign qWe		= iWe & ~oFull;
	assign qRe		= iRe & ~oEmp;
	assign oWrote	= qWe;
	// wrap-around difference is the level
	assign wCount	= rWa - rRa;
	assign oLevel	= tLevel'(wCount);

	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			rWa		<= '0;
			rRa		<= '0;
			rRvd	<= 1'b0;
			rLast	<= 1'b0;
			rAlert	<= 1'b0;
		end
		else
		begin
			if (qWe)
				rWa <= wWaNext;
			if (qRe)
				rRa <= rRa + 1'b1;
			// valid and last line up with the ram read register
			rRvd	<= qRe;
			rLast	<= qRe & iLastRead;
			rAlert	<= (oLevel >= lpBorder);
		end
	end

	assign oRvd		= rRvd;
	assign oLast	= rLast;
	assign oAlert	= rAlert;

	//----------------------------------------------------------
	// ram slices
	//----------------------------------------------------------
	logic [lpPadWidth-1:0] wWdPad;
	logic [lpPadWidth-1:0] wRdPad;

	assign wWdPad = lpPadWidth'(iWd);

	for (genvar x = 0; x < lpSliceNum; x++)
	begin : gSlice
		SdpRamSlice #(
			.pDataWidth	(lpSliceWidth),
			.pAddrWidth	(lpAddrWidth)
		) SdpRamSlice_i (
			.iCLK	(iCLK),
			.iWd	(wWdPad[x*lpSliceWidth +: lpSliceWidth]),
			.iWa	(rWa),
			.iWe	(qWe),
			.iRa	(rRa),
			.iRe	(qRe),
			.oRd	(wRdPad[x*lpSliceWidth +: lpSliceWidth])
		);
	end

	// drop pad bits
	assign oRd = wRdPad[pFifoBitWidth-1:0];

	// read requests only arrive while words are held
	aRvdFromRead: assert property (@(posedge iCLK) disable iff (!inARST)
		iRe |-> !oEmp);

	aFullEmpty: assert property (@(posedge iCLK) disable iff (!inARST)
		!(oFull && oEmp));

endmodule

// File: sim/DrainBufferTb.sv
//----------------------------------------------------------
// testbench of the burst-drain buffer
// clock, reset, lfsr, stimulus table, queue model, watchdog
//----------------------------------------------------------
`timescale 1ns/1ns
`include "drainBuffer_consts.svh"

module DrainBufferTb;

	import DrainBufferPkg::*;

	localparam int lpRows = 6;
	localparam int lpDrainLimit = 4 * (`IDLE_CYCLES + 2 * `FIFO_DEPTH);

	// dut ports
	logic iCLK;
	logic inARST;
	tWord iWd;
	logic iWe;
	logic iHold;
	tWord oRd;
	logic oRvd;
	logic oLast;
	logic oFull;
	logic oEmp;
	logic oAlert;
	logic oBusy;

	//----------------------------------------------------------
	// stimulus table
	//----------------------------------------------------------
	// hold mode 0 none, 1 held high while writing, 2 random
	// expected flags, -1 leaves the flag unchecked
	string rowName [lpRows] = '{"fillHold", "alertBurst", "idleFlush",
		"holdPulse", "sparse", "alertOnly"};
	int rowWrites [lpRows] = '{18, 12, 5, 14, 6, 10};
	int rowGap [lpRows] = '{0, 0, 2, 1, 25, 0};
	int rowHold [lpRows] = '{1, 0, 0, 2, 0, 1};
	int rowAlert [lpRows] = '{1, 1, 0, -1, 0, 1};
	int rowFull [lpRows] = '{1, 0, 0, -1, 0, 0};

	// model and bookkeeping
	tWord model [$];
	string curName;
	logic [15:0] lfsrState;
	int prevLevel;
	int holdAge;
	int burstWords;
	int dropped;
	int checkErrors;
	int otherErrors;
	logic sawAlert;
	logic sawFull;

	DrainBufferTop DrainBufferTop_i (
		.iCLK	(iCLK),
		.inARST	(inARST),
		.iWd	(iWd),
		.iWe	(iWe),
		.iHold	(iHold),
		.oRd	(oRd),
		.oRvd	(oRvd),
		.oLast	(oLast),
		.oFull	(oFull),
		.oEmp	(oEmp),
		.oAlert	(oAlert),
		.oBusy	(oBusy)
	);

	// 10 ns clock
	initial
	begin
		iCLK = 1'b0;
		forever
			#5 iCLK = ~iCLK;
	end

	//----------------------------------------------------------
	// lfsr, taps 16 14 13 11
	//----------------------------------------------------------
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// one step per bit taken
	function automatic int randBits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = lfsrStep(lfsrState);
			v = (v << 1) | lfsrState[0];
		end
		return v;
	endfunction

	function automatic logic holdFor(input int mode);
		if (mode == 1)
			return 1'b1;
		if (mode == 2)
			return (randBits(2) == 0);
		return 1'b0;
	endfunction

	//----------------------------------------------------------
	// compare tasks
	//----------------------------------------------------------
	task automatic checkWord(input string what, input tWord exp, input tWord act);
		if (act !== exp)
		begin
			checkErrors++;
			$display("CHECK FAILED %s %s: expected %0h, actual %0h", curName, what, exp, act);
		end
	endtask

	task automatic checkLevel(input string what, input tLevel exp, input tLevel act);
		if (act !== exp)
		begin
			checkErrors++;
			$display("CHECK FAILED %s %s: expected %0d, actual %0d", curName, what, exp, act);
		end
	endtask

	task automatic checkFlag(input string what, input logic exp, input logic act);
		if (act !== exp)
		begin
			checkErrors++;
			$display("CHECK FAILED %s %s: expected %b, actual %b", curName, what, exp, act);
		end
	endtask

	// one clock: check what the last edge did, then drive the next
	task automatic runCycle(input logic we, input tWord wd, input logic hold);
		tWord expWord;
		int level;
		@(negedge iCLK);
		// hold level seen by the edge just passed
		if (iHold)
			holdAge++;
		else
			holdAge = 0;
		if (oRvd)
		begin
			if (holdAge > 0)
			begin
				otherErrors++;
				$display("%s: read data came %0d cycles into a hold", curName, holdAge);
			end
			if (model.size() == 0)
			begin
				otherErrors++;
				$display("%s: read data came with no word left in the model", curName);
			end
			else
			begin
				expWord = model.pop_front();
				checkWord("order", expWord, oRd);
			end
			burstWords++;
			if (burstWords > `BURST_LEN)
			begin
				otherErrors++;
				$display("%s: burst ran past %0d words", curName, `BURST_LEN);
			end
			// pre-write level of the read edge decides the last word
			checkFlag("oLast", (burstWords == `BURST_LEN) || (prevLevel == 1), oLast);
			if (oLast)
				burstWords = 0;
		end
		else
			checkFlag("oLast without oRvd", 1'b0, oLast);
		level = model.size();
		checkLevel("fill level", tLevel'(level), DrainBufferTop_i.wLevel);
		checkFlag("oEmp", level == 0, oEmp);
		checkFlag("oFull", level == `FIFO_DEPTH - 1, oFull);
		// alert lags the level by one edge
		checkFlag("oAlert", prevLevel >= `ALERT_BORDER, oAlert);
		sawAlert = sawAlert | oAlert;
		sawFull = sawFull | oFull;
		prevLevel = level;
		iWe = we;
		iWd = wd;
		iHold = hold;
		// a write at full is lost
		if (we && (level < `FIFO_DEPTH - 1))
			model.push_back(wd);
		else if (we)
			dropped++;
	endtask

	task automatic drainAll();
		int waited;
		waited = 0;
		while (!(model.size() == 0 && oEmp && !oBusy) && (waited < lpDrainLimit))
		begin
			runCycle(1'b0, '0, 1'b0);
			waited++;
		end
		if (waited >= lpDrainLimit)
		begin
			otherErrors++;
			$display("%s: buffer did not drain within %0d cycles", curName, lpDrainLimit);
		end
	endtask

	//----------------------------------------------------------
	// main sequence
	//----------------------------------------------------------
	initial
	begin
		inARST = 1'b0;
		iWd = '0;
		iWe = 1'b0;
		iHold = 1'b0;
		lfsrState = 16'd35734;
		prevLevel = 0;
		holdAge = 0;
		burstWords = 0;
		dropped = 0;
		checkErrors = 0;
		otherErrors = 0;
		curName = "reset";
		repeat (3) @(posedge iCLK);
		@(negedge iCLK);
		inARST = 1'b1;
		// outputs right after reset
		checkFlag("oEmp", 1'b1, oEmp);
		checkFlag("oRvd", 1'b0, oRvd);
		checkFlag("oLast", 1'b0, oLast);
		checkFlag("oFull", 1'b0, oFull);
		checkFlag("oAlert", 1'b0, oAlert);
		checkFlag("oBusy", 1'b0, oBusy);
		for (int r = 0; r < lpRows; r++)
		begin
			curName = rowName[r];
			sawAlert = 1'b0;
			sawFull = 1'b0;
			for (int w = 0; w < rowWrites[r]; w++)
			begin
				runCycle(1'b1, tWord'(randBits(`DATA_WIDTH)), holdFor(rowHold[r]));
				repeat (rowGap[r])
					runCycle(1'b0, '0, holdFor(rowHold[r]));
			end
			drainAll();
			if (rowAlert[r] >= 0)
				checkFlag("alert seen", rowAlert[r] == 1, sawAlert);
			if (rowFull[r] >= 0)
				checkFlag("full seen", rowFull[r] == 1, sawFull);
			checkFlag("oEmp after drain", 1'b1, oEmp);
			checkFlag("oBusy after drain", 1'b0, oBusy);
			if (burstWords != 0)
			begin
				otherErrors++;
				$display("%s: burst left open without a last word", curName);
			end
		end
		$display("errors: %0d compare, %0d other, %0d writes lost at full",
			checkErrors, otherErrors, dropped);
		if (checkErrors == 0 && otherErrors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// watchdog, limit from the table
	initial
	begin
		int limit;
		limit = 0;
		for (int r = 0; r < lpRows; r++)
			limit += (rowWrites[r] * rowGap[r] + `IDLE_CYCLES + 2 * `FIFO_DEPTH) * 4;
		repeat (limit + 3) @(posedge iCLK);
		$display("watchdog: run did not finish within %0d cycles", limit);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: source/DrainBufferTop.sv
//----------------------------------------------------------
// burst-drain buffer top level
// fifo controller, drain timer and drain sequencer
//----------------------------------------------------------
`timescale 1ns/1ns
`include "drainBuffer_consts.svh"

module DrainBufferTop (
	input	logic					iCLK,
	input	logic					inARST,
	input	DrainBufferPkg::tWord	iWd,
	input	logic					iWe,
	input	logic					iHold,
	output	DrainBufferPkg::tWord	oRd,
	output	logic					oRvd,
	output	logic					oLast,
	output	logic					oFull,
	output	logic					oEmp,
	output	logic					oAlert,
	output	logic					oBusy
);

	import DrainBufferPkg::*;

	// fifo to sequencer and timer
	tLevel wLevel;
	logic wWrote;
	// timer to sequencer
	logic wIdleExpired;
	tBurstCnt wBurstCnt;
	// sequencer to fifo and timer
	logic wRe;
	logic wLastRead;
	logic wBurstStart;
	logic wBurstStep;

	SyncFifoController #(
		.pFifoDepth		(`FIFO_DEPTH),
		.pFifoBitWidth	(`DATA_WIDTH),
		.pAlertBorder	(`ALERT_BORDER)
	) SyncFifoController_i (
		.iCLK		(iCLK),
		.inARST		(inARST),
		.iWd		(iWd),
		.iWe		(iWe),
		.oFull		(oFull),
		.oWrote		(wWrote),
		.iRe		(wRe),
		.iLastRead	(wLastRead),
		.oRd		(oRd),
		.oRvd		(oRvd),
		.oLast		(oLast),
		.oEmp		(oEmp),
		.oAlert		(oAlert),
		.oLevel		(wLevel)
	);

	DrainTimer DrainTimer_i (
		.iCLK			(iCLK),
		.inARST			(inARST),
		.iWrote			(wWrote),
		.iBurstStart	(wBurstStart),
		.iBurstStep		(wBurstStep),
		.oIdleExpired	(wIdleExpired),
		.oBurstCnt		(wBurstCnt)
	);

	DrainSequencer DrainSequencer_i (
		.iCLK			(iCLK),
		.inARST			(inARST),
		.iAlert			(oAlert),
		.iIdleExpired	(wIdleExpired),
		.iEmp			(oEmp),
		.iHold			(iHold),
		.iLevel			(wLevel),
		.iBurstCnt		(wBurstCnt),
		.oRe			(wRe),
		.oLastRead		(wLastRead),
		.oBurstStart	(wBurstStart),
		.oBurstStep		(wBurstStep),
		.oBusy			(oBusy)
	);

endmodule

// File: source/DrainSequencer.sv
//----------------------------------------------------------
// drain sequencer FSM, idle / drain / hold
// burst start, one read per cycle, last-read marking
//----------------------------------------------------------
`timescale 1ns/1ns
`include "drainBuffer_consts.svh"

module DrainSequencer (
	input	logic						iCLK,
	input	logic						inARST,
	input	logic						iAlert,
	input	logic						iIdleExpired,
	input	logic						iEmp,
	input	logic						iHold,
	input	DrainBufferPkg::tLevel		iLevel,
	input	DrainBufferPkg::tBurstCnt	iBurstCnt,
	output	logic						oRe,
	output	logic						oLastRead,
	output	logic						oBurstStart,
	output	logic						oBurstStep,
	output	logic						oBusy
);

	import DrainBufferPkg::*;

	localparam tBurstCnt lpLastCnt = tBurstCnt'(`BURST_LEN - 1);
	localparam tLevel lpOneWord = tLevel'(1);

	tDrainState rState;
	tDrainState qNext;
	logic qTrigger;
	logic qLast;
	logic qRe;
	logic qStart;

	// burst trigger, fifo must hold data
	assign qTrigger = (iAlert | iIdleExpired) & ~iEmp;
	// level is pre-write, a word written now waits for the next burst
	assign qLast = (iBurstCnt == lpLastCnt) || (iLevel == lpOneWord);

	//----------------------------------------------------------
	// next state
	//----------------------------------------------------------
	always_comb
	begin
		qNext	= rState;
		qRe		= 1'b0;
		qStart	= 1'b0;
		case (rState)
			Idle:
			begin
				if (qTrigger)
				begin
					qNext	= Drain;
					qStart	= 1'b1;
				end
			end
			Drain:
			begin
				// stall before any read is issued
				if (iHold)
					qNext = Hold;
				else if (iEmp)
					qNext = Idle;
				else
				begin
					qRe = 1'b1;
					if (qLast)
						qNext = Idle;
				end
			end
			Hold:
			begin
				// burst count kept across the pause
				if (!iHold)
					qNext = Drain;
			end
			default:
				qNext = Idle;
		endcase
	end

	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
			rState <= Idle;
		else
			rState <= qNext;
	end

	// outputs
	assign oRe			= qRe;
	assign oBurstStep	= qRe;
	assign oLastRead	= qRe & qLast;
	assign oBurstStart	= qStart;
	assign oBusy		= (rState != Idle);

	aNoReadOnHold: assert property (@(posedge iCLK) disable iff (!inARST)
		!(oRe && iHold));

endmodule

// File: source/DrainTimer.sv
//----------------------------------------------------------
// idle timer since the last accepted write
// word counter of the running drain burst
//----------------------------------------------------------
`timescale 1ns/1ns
`include "drainBuffer_consts.svh"

module DrainTimer (
	input	logic						iCLK,
	input	logic						inARST,
	input	logic						iWrote,
	input	logic						iBurstStart,
	input	logic						iBurstStep,
	output	logic						oIdleExpired,
	output	DrainBufferPkg::tBurstCnt	oBurstCnt
);

	import DrainBufferPkg::*;

	localparam int lpIdleWidth = $clog2(`IDLE_CYCLES + 1);
	localparam logic [lpIdleWidth-1:0] lpIdleMax = lpIdleWidth'(`IDLE_CYCLES);
	localparam tBurstCnt lpBurstMax = tBurstCnt'(`BURST_LEN - 1);

	logic [lpIdleWidth-1:0] rIdleCnt;
	tBurstCnt rBurstCnt;

	//----------------------------------------------------------
	// idle counter
	//----------------------------------------------------------
	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
			rIdleCnt <= '0;
		else if (iWrote)
			rIdleCnt <= '0;
		// saturate at the idle time
		else if (rIdleCnt != lpIdleMax)
			rIdleCnt <= rIdleCnt + 1'b1;
	end

	// level, stays high until the next write
	assign oIdleExpired = (rIdleCnt == lpIdleMax);

	//----------------------------------------------------------
	// burst word counter
	//----------------------------------------------------------
	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
			rBurstCnt <= '0;
		else if (iBurstStart)
			rBurstCnt <= '0;
		// last read of a burst leaves the count at its top
		else if (iBurstStep && (rBurstCnt != lpBurstMax))
			rBurstCnt <= rBurstCnt + 1'b1;
	end

	assign oBurstCnt = rBurstCnt;

	aBurstCntRange: assert property (@(posedge iCLK) disable iff (!inARST)
		oBurstCnt <= lpBurstMax);

endmodule

// File: source/SdpRamSlice.sv
//----------------------------------------------------------
// simple-dual-port ram slice
// sync write port, registered read port with read enable
//----------------------------------------------------------
`timescale 1ns/1ns

module SdpRamSlice #(
	parameter int pDataWidth = 1,
	parameter int pAddrWidth = 4
)(
	input	logic					iCLK,
	// write side
	input	logic [pDataWidth-1:0]	iWd,
	input	logic [pAddrWidth-1:0]	iWa,
	input	logic					iWe,
	// read side
	input	logic [pAddrWidth-1:0]	iRa,
	input	logic					iRe,
	output	logic [pDataWidth-1:0]	oRd
);

	// storage array
	logic [pDataWidth-1:0] rMem [0:(2**pAddrWidth)-1];

	// read data register
	logic [pDataWidth-1:0] rRd;

	always_ff @(posedge iCLK)
	begin
		// write port
		if (iWe)
			rMem[iWa] <= iWd;
		// read port, holds between reads like block ram
		if (iRe)
			rRd <= rMem[iRa];
	end

	assign oRd = rRd;

endmodule

// File: tb.f
+incdir+common
common/DrainBufferPkg.sv
source/SdpRamSlice.sv
fifo/SyncFifoController.sv
source/DrainTimer.sv
source/DrainSequencer.sv
source/DrainBufferTop.sv
sim/DrainBufferTb.sv
